/* src.f */
+incdir+rtl
rtl/boot_pkg.sv
rtl/rom_loader.sv
rtl/mem_arbiter.sv
rtl/pll_reconf_seq.sv
rtl/word_ram.sv
rtl/boot_subsys_top.sv
verification/boot_subsys_tb.sv

/* verification/boot_subsys_tb.sv */
`timescale 1ns/1ps
`include "boot_config.svh"

module boot_subsys_tb;

	import boot_pkg::*;

	// about 330 cycles of rom load, 100 for the ignored download,
	// 240 of prefill and read-back, 120 of core access,
	// 1100 for the pll timeout, then roughly double for margin
	localparam int MAX_CYCLES = 4000;
	localparam int REGION_WORDS = 16;
	localparam int WATCH_ACK = 0;
	localparam int WATCH_WFR = 1;
	localparam int WATCH_RECONF = 2;
	localparam int WATCH_RRST = 3;
	localparam int WATCH_RUN = 4;

	logic        clk_sys = 1'b0;
	logic        reset_i;
	logic        downloading_i;
	logic [7:0]  dio_index_i;
	logic [7:0]  byte_i;
	logic        byte_stb_i;
	mem_req_t    core_req_i;
	logic        core_ack_o;
	logic [31:0] core_rdat_o;
	logic        core_reset_o;
	logic [1:0]  clk_select_i;
	logic        busy_i;
	logic        write_from_rom_o;
	logic        reconfig_o;
	logic        reconf_reset_o;

	logic [31:0] model [`BOOT_RAM_WORDS];	// mirror of word_ram
	logic [15:0] lfsr = 16'd35561;
	logic        rom_loaded = 1'b0;	// set once a rom download has finished
	int          cycle = 0;
	int          errors = 0;
	int          checks = 0;
	int          ack_cnt;
	int          wfr_cnt;
	int          rc_cnt;
	int          rr_cnt;
	int          wfr_base;
	int          rc_base;
	int          rr_base;

	boot_subsys_top dut (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		if (cycle == MAX_CYCLES) begin
			$display("tests did not finish within %0d cycles, run stopped", MAX_CYCLES);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// pulse counters, sampled mid cycle
	always @(negedge clk_sys) begin
		ack_cnt <= ack_cnt + core_ack_o;
		wfr_cnt <= wfr_cnt + write_from_rom_o;
		rc_cnt <= rc_cnt + reconfig_o;
		rr_cnt <= rr_cnt + reconf_reset_o;
	end

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);	// galois, taps 16 14 13 11
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int word_index(input logic [`BOOT_ADDR_W-1:0] adr);
		return (adr >> 2) % `BOOT_RAM_WORDS;	// ram aliases the upper address bits
	endfunction

	function automatic logic watched(input int which);
		case (which)
			WATCH_ACK: return core_ack_o;
			WATCH_WFR: return write_from_rom_o;
			WATCH_RECONF: return reconfig_o;
			WATCH_RRST: return reconf_reset_o;
			default: return !core_reset_o;
		endcase
	endfunction

	function automatic logic [31:0] pulse_counts();
		int w;
		int r;
		int t;
		w = wfr_cnt - wfr_base;
		r = rc_cnt - rc_base;
		t = rr_cnt - rr_base;
		return {8'h00, w[7:0], r[7:0], t[7:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic wait_for(input int which, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!watched(which) && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (!watched(which)) begin
			errors++;
			$display("%s did not show up within %0d cycles", what, limit);
		end
	endtask

	task automatic core_access(input string name, input logic we,
			input logic [`BOOT_ADDR_W-1:0] adr, input logic [31:0] dat, input logic [3:0] sel);
		int          idx;
		int          ack_base;
		logic [31:0] rdat;
		idx = word_index(adr);
		@(posedge clk_sys);
		ack_base = ack_cnt;
		core_req_i <= {adr, dat, sel, we, 1'b1};
		wait_for(WATCH_ACK, 8, $sformatf("%s ack", name));
		rdat = core_rdat_o;
		@(posedge clk_sys);
		core_req_i.stb <= 1'b0;	// dropped the cycle after ack
		repeat (2) @(posedge clk_sys);
		check_value($sformatf("%s_acks", name), 1, ack_cnt - ack_base);
		if (we) begin
			for (int b = 0; b < 4; b++)
				if (sel[b])
					model[idx][b*8 +: 8] = dat[b*8 +: 8];
		end else
			check_value(name, model[idx], rdat);
	endtask

	task automatic read_back(input string name);
		logic [`BOOT_ADDR_W-1:0] adr;
		for (int i = 0; i < REGION_WORDS; i++) begin
			adr = `BOOT_START_ADDR + 4 * i;
			core_access($sformatf("%s%0d", name, i), 1'b0, adr, 32'h0, 4'hF);
		end
	endtask

	task automatic download(input string name, input logic [7:0] index, input int count);
		logic                    rom;
		logic                    exp_rst;
		int                      ack_base;
		logic [7:0]              b;
		logic [`BOOT_ADDR_W-1:0] adr;
		rom = (index == `BOOT_ROM_IDX_A) || (index == `BOOT_ROM_IDX_B);
		@(posedge clk_sys);
		downloading_i <= 1'b1;
		dio_index_i <= index;
		@(posedge clk_sys);
		ack_base = ack_cnt;
		if (rom)
			core_req_i <= {`BOOT_START_ADDR, 32'h0, 4'hF, 1'b0, 1'b1};	// must stay unserved
		exp_rst = !rom_loaded;	// core held until the first rom load ends
		for (int i = 0; i < count; i++) begin
			b = take_bits(8);
			repeat (4 + take_bits(3)) @(posedge clk_sys);
			byte_i <= b;
			byte_stb_i <= 1'b1;
			@(posedge clk_sys);
			byte_stb_i <= 1'b0;
			if (rom) begin
				adr = `BOOT_START_ADDR + 4 * (i / 4);
				model[word_index(adr)][(i % 4) * 8 +: 8] = b;	// lane 0 first
			end
			@(negedge clk_sys);
			check_value($sformatf("%s_core_reset", name), exp_rst, core_reset_o);
		end
		repeat (4 + take_bits(2)) @(posedge clk_sys);
		downloading_i <= 1'b0;
		core_req_i.stb <= 1'b0;
		if (rom) begin
			check_value($sformatf("%s_core_blocked", name), 0, ack_cnt - ack_base);
			rom_loaded = 1'b1;
		end
	endtask

	task automatic change_select(input logic [1:0] sel);
		@(posedge clk_sys);
		wfr_base = wfr_cnt;
		rc_base = rc_cnt;
		rr_base = rr_cnt;
		clk_select_i <= sel;
		wait_for(WATCH_WFR, 4, "write_from_rom_o pulse");
	endtask

	initial begin
		int                      hold;
		int                      t0;
		logic [`BOOT_ADDR_W-1:0] adr;
		logic [`BOOT_ADDR_W-1:0] addrs [12];
		logic [31:0]             dat;
		logic [3:0]              sel;
		reset_i = 1'b1;
		downloading_i = 1'b0;
		dio_index_i = 8'd0;
		byte_i = 8'd0;
		byte_stb_i = 1'b0;
		core_req_i = '0;
		clk_select_i = 2'd0;
		busy_i = 1'b0;
		repeat (15) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("reset_held", 32'b10000,
			{core_reset_o, core_ack_o, write_from_rom_o, reconfig_o, reconf_reset_o});
		@(posedge clk_sys);
		reset_i <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("reset_released", 32'b10000,
			{core_reset_o, core_ack_o, write_from_rom_o, reconfig_o, reconf_reset_o});

		// known pattern under the rom region so untouched lanes show
		for (int i = 0; i < REGION_WORDS; i++) begin
			adr = `BOOT_START_ADDR + 4 * i;
			core_access("prefill", 1'b1, adr, {8'hA5, adr}, 4'hF);
		end
		download("rom_load", `BOOT_ROM_IDX_A, 37);
		wait_for(WATCH_RUN, 8, "core_reset_o release");
		repeat (4) @(posedge clk_sys);
		read_back("rom_word");
		download("other_index", 8'd5, 12);
		read_back("kept_word");

		// random high bits land on the same ram words
		for (int i = 0; i < 12; i++) begin
			adr = take_bits(14) << 10;
			addrs[i] = adr | (take_bits(4) << 2);
			dat = take_bits(32);
			sel = take_bits(4);
			core_access("core_write", 1'b1, addrs[i], dat, sel);
		end
		for (int i = 0; i < 12; i++)
			core_access($sformatf("core_read%0d", i), 1'b0, addrs[i], 32'h0, 4'hF);

		change_select(2'd1);
		hold = 3 + take_bits(5) % 18;
		@(posedge clk_sys);
		busy_i <= 1'b1;
		repeat (hold) @(posedge clk_sys);
		check_value("pll_reconfig_while_busy", 0, rc_cnt - rc_base);
		busy_i <= 1'b0;
		wait_for(WATCH_RECONF, 6, "reconfig_o pulse");
		repeat (4) @(posedge clk_sys);
		check_value("pll_change_pulses", 32'h01_01_00, pulse_counts());

		change_select(2'd2);
		wait_for(WATCH_RECONF, 6, "reconfig_o pulse");
		t0 = cycle;
		@(posedge clk_sys);
		busy_i <= 1'b1;	// controller never finishes
		wait_for(WATCH_RRST, `BOOT_RECONF_TIMEOUT + 20, "reconf_reset_o pulse");
		check_value("pll_timeout_not_early", 1, (cycle - t0) >= `BOOT_RECONF_TIMEOUT);
		repeat (4) @(posedge clk_sys);
		check_value("pll_stuck_pulses", 32'h01_01_01, pulse_counts());
		busy_i <= 1'b0;
		change_select(2'd3);
		wait_for(WATCH_RECONF, 6, "reconfig_o pulse");
		repeat (4) @(posedge clk_sys);
		check_value("pll_recovered_pulses", 32'h01_01_00, pulse_counts());

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* rtl/boot_subsys_top.sv */
`timescale 1ns/1ps

module boot_subsys_top (
	input  logic               clk_sys,
	input  logic               reset_i,
	input  logic               downloading_i,
	input  logic [7:0]         dio_index_i,
	input  logic [7:0]         byte_i,
	input  logic               byte_stb_i,
	input  boot_pkg::mem_req_t core_req_i,
	output logic               core_ack_o,
	output logic [31:0]        core_rdat_o,
	output logic               core_reset_o,
	input  logic [1:0]         clk_select_i,
	input  logic               busy_i,
	output logic               write_from_rom_o,
	output logic               reconfig_o,
	output logic               reconf_reset_o
);

	import boot_pkg::*;

	load_word_t  loader_word;
	logic        loader_wr;
	logic        loader_active;	// rom download in progress
	mem_req_t    ram_req;
	logic        ram_ack;
	logic [31:0] ram_rdat;

	rom_loader u_rom_loader (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.downloading_i (downloading_i),
		.dio_index_i   (dio_index_i),
		.byte_i        (byte_i),
		.byte_stb_i    (byte_stb_i),
		.load_o        (loader_word),
		.wr_o          (loader_wr),
		.loading_o     (loader_active)
	);

	mem_arbiter u_mem_arbiter (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.load_i       (loader_word),
		.wr_i         (loader_wr),
		.loading_i    (loader_active),
		.core_req_i   (core_req_i),
		.core_ack_o   (core_ack_o),
		.core_rdat_o  (core_rdat_o),
		.core_reset_o (core_reset_o),
		.ram_req_o    (ram_req),
		.ram_ack_i    (ram_ack),
		.ram_rdat_i   (ram_rdat)
	);

	// stands in for the sdram controller
	word_ram u_word_ram (
		.clk_sys (clk_sys),
		.reset_i (reset_i),
		.req_i   (ram_req),
		.ack_o   (ram_ack),
		.rdat_o  (ram_rdat)
	);

	pll_reconf_seq u_pll_reconf_seq (
		.clk_sys          (clk_sys),
		.reset_i          (reset_i),
		.clk_select_i     (clk_select_i),
		.busy_i           (busy_i),
		.write_from_rom_o (write_from_rom_o),
		.reconfig_o       (reconfig_o),
		.reconf_reset_o   (reconf_reset_o)
	);

endmodule

/* rtl/word_ram.sv */
`timescale 1ns/1ps
`include "boot_config.svh"

module word_ram (
	input  logic               clk_sys,
	input  logic               reset_i,
	input  boot_pkg::mem_req_t req_i,
	output logic               ack_o,
	output logic [31:0]        rdat_o
);

	localparam int IDX_W = $clog2(`BOOT_RAM_WORDS);

	logic [31:0]      mem [`BOOT_RAM_WORDS];
	logic [IDX_W-1:0] idx;
	logic             take;	// new request accepted this cycle

	assign idx = req_i.adr[IDX_W+1:2];	// upper address bits alias
	assign take = req_i.stb & ~ack_o;

	always_ff @(posedge clk_sys) begin
		if (reset_i)
			ack_o <= 1'b0;
		else
			ack_o <= take;	// request still up after ack is not served again
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			rdat_o <= mem[idx];
			if (req_i.we) begin
				for (int b = 0; b < 4; b++) begin
					if (req_i.sel[b])
						mem[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
				end
			end
		end
	end

endmodule

/* rtl/pll_reconf_seq.sv */
`timescale 1ns/1ps
`include "boot_config.svh"

module pll_reconf_seq (
	input  logic       clk_sys,
	input  logic       reset_i,
	input  logic [1:0] clk_select_i,
	input  logic       busy_i,
	output logic       write_from_rom_o,
	output logic       reconfig_o,
	output logic       reconf_reset_o
);

	localparam int TMO_W = $clog2(`BOOT_RECONF_TIMEOUT + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DELAY,	// one cycle after write_from_rom
		ST_WAIT_FREE,	// wait for busy low before reconfig
		ST_WAIT_DONE
	} state_t;

	state_t           state;
	logic [1:0]       sel_d;
	logic [TMO_W-1:0] tmo_q;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			state <= ST_IDLE;
			sel_d <= clk_select_i;	// no reconfig for the select seen at reset
			tmo_q <= '0;
			write_from_rom_o <= 1'b0;
			reconfig_o <= 1'b0;
			reconf_reset_o <= 1'b0;
		end else begin
			write_from_rom_o <= 1'b0;
			reconfig_o <= 1'b0;
			reconf_reset_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					sel_d <= clk_select_i;
					if (sel_d != clk_select_i) begin
						write_from_rom_o <= 1'b1;	// load new settings from rom
						tmo_q <= TMO_W'(`BOOT_RECONF_TIMEOUT);
						state <= ST_DELAY;
					end
				end
				ST_DELAY: state <= ST_WAIT_FREE;
				ST_WAIT_FREE: begin
					tmo_q <= tmo_q - 1'b1;
					if (!busy_i) begin
						reconfig_o <= 1'b1;
						tmo_q <= TMO_W'(`BOOT_RECONF_TIMEOUT);
						state <= ST_WAIT_DONE;
					end else if (tmo_q == TMO_W'(1)) begin
						reconf_reset_o <= 1'b1;	// controller stuck
						state <= ST_IDLE;
					end
				end
				ST_WAIT_DONE: begin
					tmo_q <= tmo_q - 1'b1;
					if (!reconfig_o && !busy_i)
						state <= ST_IDLE;
					else if (tmo_q == TMO_W'(1)) begin
						reconf_reset_o <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps
`include "boot_config.svh"

module mem_arbiter (
	input  logic                 clk_sys,
	input  logic                 reset_i,
	input  boot_pkg::load_word_t load_i,
	input  logic                 wr_i,
	input  logic                 loading_i,
	input  boot_pkg::mem_req_t   core_req_i,
	output logic                 core_ack_o,
	output logic [31:0]          core_rdat_o,
	output logic                 core_reset_o,
	output boot_pkg::mem_req_t   ram_req_o,
	input  logic                 ram_ack_i,
	input  logic [31:0]          ram_rdat_i
);

	import boot_pkg::*;

	logic     loader_stb;
	logic     loading_d;
	logic     rom_ready;
	logic     load_own;	// loader owns the ram bus
	mem_req_t loader_req;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			loader_stb <= 1'b0;
			loading_d <= 1'b0;
			rom_ready <= 1'b0;
		end else begin
			loading_d <= loading_i;
			if (loading_d && !loading_i)
				rom_ready <= 1'b1;	// sticky until reset
			if (wr_i)
				loader_stb <= 1'b1;
			else if (ram_ack_i)
				loader_stb <= 1'b0;
		end
	end

	// the partial last word is written just after loading_i drops,
	// so ownership stretches until that cycle has finished
	assign load_own = loading_i | loading_d | wr_i | loader_stb;

	assign loader_req.adr = {load_i.adr[`BOOT_ADDR_W-1:2], 2'b00};
	assign loader_req.dat = load_i.dat;
	assign loader_req.sel = load_i.sel;
	assign loader_req.we = 1'b1;	// loader only writes
	assign loader_req.stb = loader_stb;

	assign ram_req_o = load_own ? loader_req : core_req_i;
	assign core_ack_o = ram_ack_i & ~load_own;	// acks during a load belong to the loader
	assign core_rdat_o = ram_rdat_i;
	assign core_reset_o = ~rom_ready;

endmodule

/* rtl/rom_loader.sv */
`timescale 1ns/1ps
`include "boot_config.svh"

module rom_loader (
	input  logic                 clk_sys,
	input  logic                 reset_i,
	input  logic                 downloading_i,
	input  logic [7:0]           dio_index_i,
	input  logic [7:0]           byte_i,
	input  logic                 byte_stb_i,
	output boot_pkg::load_word_t load_o,
	output logic                 wr_o,
	output logic                 loading_o
);

	logic                    rom_idx;
	logic                    loading_d;
	logic                    load_end;	// falling edge of a rom download
	logic [1:0]              byte_cnt;
	logic [31:0]             word_q;
	logic [`BOOT_ADDR_W-1:0] addr_q;

	assign rom_idx = (dio_index_i == `BOOT_ROM_IDX_A) || (dio_index_i == `BOOT_ROM_IDX_B);
	assign loading_o = downloading_i & rom_idx;
	assign load_end = loading_d & ~loading_o;

	// byte counter, address and write strobe
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			loading_d <= 1'b0;
			wr_o <= 1'b0;
			byte_cnt <= 2'd0;
			addr_q <= `BOOT_START_ADDR;
		end else begin
			loading_d <= loading_o;
			wr_o <= 1'b0;
			if (loading_o && byte_stb_i) begin
				byte_cnt <= byte_cnt + 2'd1;
				if (byte_cnt == 2'd3) begin	// fourth byte completes the word
					wr_o <= 1'b1;
					addr_q <= addr_q + `BOOT_ADDR_W'(4);
				end
			end else if (load_end) begin
				wr_o <= (byte_cnt != 2'd0);	// flush a partial word
				byte_cnt <= 2'd0;
				addr_q <= `BOOT_START_ADDR;
			end else if (!loading_o) begin
				// idle, next download starts from the base again
				byte_cnt <= 2'd0;
				addr_q <= `BOOT_START_ADDR;
			end
		end
	end

	// word assembly, lowest lane first
	always_ff @(posedge clk_sys) begin
		if (loading_o && byte_stb_i) begin
			word_q[{byte_cnt, 3'b000} +: 8] <= byte_i;
			if (byte_cnt == 2'd3) begin
				load_o.adr <= addr_q;
				load_o.dat <= {byte_i, word_q[23:0]};
				load_o.sel <= 4'b1111;
			end
		end else if (load_end) begin
			load_o.adr <= addr_q;
			load_o.dat <= word_q;
			load_o.sel <= (4'b0001 << byte_cnt) - 4'd1;	// lanes received so far
		end
	end

endmodule

/* rtl/boot_pkg.sv */
`include "boot_config.svh"

package boot_pkg;

	// one request on the shared memory bus
	// stb doubles as the cycle signal
	typedef struct packed {
		logic [`BOOT_ADDR_W-1:0] adr;	// byte address, word aligned
		logic [31:0]             dat;	// write data
		logic [3:0]              sel;	// byte lane selects
		logic                    we;
		logic                    stb;
	} mem_req_t;

	// one word assembled by the rom loader
	typedef struct packed {
		logic [`BOOT_ADDR_W-1:0] adr;
		logic [31:0]             dat;
		logic [3:0]              sel;	// partial words only select received lanes
	} load_word_t;

endpackage

/* rtl/boot_config.svh */
`ifndef BOOT_CONFIG_SVH
`define BOOT_CONFIG_SVH

// byte address width of the shared memory bus
`define BOOT_ADDR_W 24

// first word written by a rom download
`define BOOT_START_ADDR 24'h40_0000

// depth of the stand-in ram, only the low word address bits are decoded
`define BOOT_RAM_WORDS 256

// download indices that count as rom loads
`define BOOT_ROM_IDX_A 8'd1
`define BOOT_ROM_IDX_B 8'd2

// cycles before a busy pll reconfig controller gets reset
`define BOOT_RECONF_TIMEOUT 1000

`endif
